// ==== common/ex_params.svh ====
`ifndef EX_PARAMS_SVH
`define EX_PARAMS_SVH

////////////////////////////////////////////////////////////
// execute stage widths
////////////////////////////////////////////////////////////

// integer data word
`define EX_XLEN 32

// register file address, 64 entries
`define EX_RADDR_W 6

// shift amount, log2 of the word width
`define EX_SHAMT_W 5

`endif

// ==== common/ex_types_pkg.sv ====
`include "ex_params.svh"

package ex_types_pkg;

  // one register file data word
  typedef logic [`EX_XLEN-1:0] word_t;

  // full product of two words
  typedef logic [2*`EX_XLEN-1:0] dword_t;

  // register file address
  typedef logic [`EX_RADDR_W-1:0] reg_addr_t;

  // shift amount, low bits of operand b
  typedef logic [`EX_SHAMT_W-1:0] shamt_t;

endpackage

// ==== common/ex_ops_pkg.sv ====
package ex_ops_pkg;

  import ex_types_pkg::*;

  ////////////////////////////////////////////////////////////
  // operation encodings
  ////////////////////////////////////////////////////////////

  // alu ops, compare group in the upper half
  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLL,
    ALU_SRL,
    ALU_SRA,
    ALU_SLT,
    ALU_SLTU,
    ALU_EQ,
    ALU_NE,
    ALU_LT,
    ALU_GE,
    ALU_LTU,
    ALU_GEU
  } alu_op_e;

  // mul is low word, the rest are high words
  typedef enum logic [1:0] {
    MULT_MUL,
    MULT_MULH,
    MULT_MULHSU,
    MULT_MULHU
  } mult_op_e;

  // second cycle of a high-word product
  typedef enum logic {
    MULT_IDLE,
    MULT_HIGH_DONE
  } mult_state_e;

  ////////////////////////////////////////////////////////////
  // request and write port bundles
  ////////////////////////////////////////////////////////////

  // operand_c carries the jump target
  typedef struct packed {
    alu_op_e op;
    word_t   operand_a;
    word_t   operand_b;
    word_t   operand_c;
  } alu_req_t;

  typedef struct packed {
    mult_op_e op;
    word_t    operand_a;
    word_t    operand_b;
  } mult_req_t;

  // one register file write port
  typedef struct packed {
    logic      we;
    reg_addr_t waddr;
    word_t     data;
  } wb_port_t;

endpackage

// ==== src/ex_alu.sv ====
`timescale 1ns/10ps
`include "ex_params.svh"

module ex_alu (
  input  ex_ops_pkg::alu_req_t alu_req_i,
  input  logic                 alu_en_i,
  output ex_types_pkg::word_t  result_o,
  output logic                 comparison_result_o
);

  import ex_types_pkg::*;
  import ex_ops_pkg::*;

  word_t  op_a;
  word_t  op_b;
  shamt_t shamt;

  // shared adder for add and sub
  logic   is_sub;
  word_t  adder_b;
  word_t  adder_result;

  // raw compare flags
  logic   is_equal;
  logic   lt_signed;
  logic   lt_unsigned;

  assign op_a  = alu_req_i.operand_a;
  assign op_b  = alu_req_i.operand_b;
  // only the low bits of b count for shifts
  assign shamt = alu_req_i.operand_b[`EX_SHAMT_W-1:0];

  ////////////////////////////////////////////////////////////
  // adder
  ////////////////////////////////////////////////////////////

  assign is_sub       = (alu_req_i.op == ALU_SUB);
  // two's complement of b, carry in below
  assign adder_b      = is_sub ? ~op_b : op_b;
  assign adder_result = op_a + adder_b + word_t'(is_sub);

  ////////////////////////////////////////////////////////////
  // comparator
  ////////////////////////////////////////////////////////////

  assign is_equal    = (op_a == op_b);
  assign lt_signed   = ($signed(op_a) < $signed(op_b));
  assign lt_unsigned = (op_a < op_b);

  // branch decision and set-less-than bit
  always_comb begin
    case (alu_req_i.op)
      ALU_EQ:           comparison_result_o = is_equal;
      ALU_NE:           comparison_result_o = ~is_equal;
      ALU_LT, ALU_SLT:  comparison_result_o = lt_signed;
      ALU_GE:           comparison_result_o = ~lt_signed;
      ALU_LTU, ALU_SLTU: comparison_result_o = lt_unsigned;
      ALU_GEU:          comparison_result_o = ~lt_unsigned;
      default:          comparison_result_o = 1'b0;
    endcase
  end

  ////////////////////////////////////////////////////////////
  // result mux
  ////////////////////////////////////////////////////////////

  always_comb begin
    case (alu_req_i.op)
      ALU_ADD, ALU_SUB: result_o = adder_result;
      ALU_AND:          result_o = op_a & op_b;
      ALU_OR:           result_o = op_a | op_b;
      ALU_XOR:          result_o = op_a ^ op_b;
      ALU_SLL:          result_o = op_a << shamt;
      ALU_SRL:          result_o = op_a >> shamt;
      // arithmetic shift keeps the sign
      ALU_SRA:          result_o = word_t'($signed(op_a) >>> shamt);
      // compare group, flag lands in bit 0
      default:          result_o = word_t'(comparison_result_o);
    endcase
  end

  // all sixteen codes are alu ops
  // only x or z bits make an illegal opcode
  always_comb begin
    if (alu_en_i) begin
      a_legal_op: assert (!$isunknown(alu_req_i.op))
        else $error("alu op not a legal encoding");
    end
  end

endmodule

// ==== src/ex_mult.sv ====
`timescale 1ns/10ps
`include "ex_params.svh"

module ex_mult (
  input  logic                  clk,
  input  logic                  rst_n,
  input  ex_ops_pkg::mult_req_t mult_req_i,
  input  logic                  mult_en_i,
  input  logic                  ex_ready_i,
  output ex_types_pkg::word_t   result_o,
  output logic                  mult_ready_o,
  output logic                  mult_multicycle_o
);

  import ex_types_pkg::*;
  import ex_ops_pkg::*;

  mult_state_e state_q;
  mult_state_e state_d;

  // operands with one extra sign bit each
  logic signed [`EX_XLEN:0]     op_a_ext;
  logic signed [`EX_XLEN:0]     op_b_ext;
  logic signed [2*`EX_XLEN+1:0] prod_full;
  dword_t                       product;

  logic  high_op;
  word_t high_q;

  ////////////////////////////////////////////////////////////
  // product
  ////////////////////////////////////////////////////////////

  // a signed for mulh and mulhsu, b signed for mulh only
  assign op_a_ext = {(mult_req_i.op == MULT_MULH || mult_req_i.op == MULT_MULHSU)
                     & mult_req_i.operand_a[`EX_XLEN-1], mult_req_i.operand_a};
  assign op_b_ext = {(mult_req_i.op == MULT_MULH) & mult_req_i.operand_b[`EX_XLEN-1],
                     mult_req_i.operand_b};

  assign prod_full = op_a_ext * op_b_ext;
  assign product   = prod_full[2*`EX_XLEN-1:0];

  assign high_op = (mult_req_i.op != MULT_MUL);

  ////////////////////////////////////////////////////////////
  // high word FSM
  ////////////////////////////////////////////////////////////

  always_comb begin
    state_d = state_q;
    case (state_q)
      MULT_IDLE: begin
        if (mult_en_i && high_op) begin
          state_d = MULT_HIGH_DONE;
        end
      end
      // leave only when the stage moves on
      MULT_HIGH_DONE: begin
        if (ex_ready_i) begin
          state_d = MULT_IDLE;
        end
      end
      default: state_d = MULT_IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= MULT_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // capture high word in the first cycle
  always_ff @(posedge clk) begin
    if (state_q == MULT_IDLE && mult_en_i && high_op) begin
      high_q <= product[2*`EX_XLEN-1:`EX_XLEN];
    end
  end

  // stall only in the first cycle of a high op
  assign mult_ready_o      = !(state_q == MULT_IDLE && mult_en_i && high_op);
  assign mult_multicycle_o = (state_q == MULT_HIGH_DONE);
  assign result_o          = mult_multicycle_o ? high_q : product[`EX_XLEN-1:0];

  // a stalled request stays on the inputs
  a_hold_en: assert property (@(posedge clk) disable iff (!rst_n)
    (!mult_ready_o && !ex_ready_i) |=> mult_en_i)
    else $error("multiplier enable dropped while stalled");

  // held high op keeps its opcode into the second cycle
  a_stable_op: assert property (@(posedge clk) disable iff (!rst_n)
    (state_q == MULT_HIGH_DONE && $past(!ex_ready_i)) |-> $stable(mult_req_i.op))
    else $error("multiplier op changed in high_done");

endmodule

// ==== src/ex_writeback.sv ====
`timescale 1ns/10ps

module ex_writeback (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    alu_en_i,
  input  logic                    mult_en_i,
  input  logic                    csr_access_i,
  input  ex_types_pkg::word_t     alu_result_i,
  input  ex_types_pkg::word_t     mult_result_i,
  input  ex_types_pkg::word_t     csr_rdata_i,
  input  ex_types_pkg::word_t     lsu_rdata_i,
  input  logic                    regfile_alu_we_i,
  input  logic                    regfile_we_i,
  input  ex_types_pkg::reg_addr_t regfile_alu_waddr_i,
  input  ex_types_pkg::reg_addr_t regfile_waddr_i,
  input  logic                    ex_valid_i,
  input  logic                    wb_ready_i,
  output ex_ops_pkg::wb_port_t    fw_o,
  output ex_ops_pkg::wb_port_t    wb_o
);

  import ex_types_pkg::*;

  // EX/WB load port state
  logic      lsu_we_q;
  reg_addr_t lsu_waddr_q;
  word_t     fw_data;

  ////////////////////////////////////////////////////////////
  // forwarding port
  ////////////////////////////////////////////////////////////

  // csr over mult over alu
  always_comb begin
    if (csr_access_i) begin
      fw_data = csr_rdata_i;
    end else if (mult_en_i) begin
      fw_data = mult_result_i;
    end else if (alu_en_i) begin
      fw_data = alu_result_i;
    end else begin
      fw_data = '0;
    end
  end

  assign fw_o.we    = regfile_alu_we_i;
  assign fw_o.waddr = regfile_alu_waddr_i;
  assign fw_o.data  = fw_data;

  ////////////////////////////////////////////////////////////
  // EX/WB register, load port
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      lsu_we_q    <= 1'b0;
      lsu_waddr_q <= '0;
    end else if (ex_valid_i) begin
      lsu_we_q <= regfile_we_i;
      // address only moves with a real write
      if (regfile_we_i) begin
        lsu_waddr_q <= regfile_waddr_i;
      end
    end else if (wb_ready_i) begin
      // bubble, flush the slot
      lsu_we_q <= 1'b0;
    end
  end

  // load data comes straight from the lsu
  assign wb_o.we    = lsu_we_q;
  assign wb_o.waddr = lsu_waddr_q;
  assign wb_o.data  = lsu_rdata_i;

  a_no_we_in_reset: assert property (@(posedge clk) !rst_n |-> !wb_o.we)
    else $error("load port write enable high in reset");

endmodule

// ==== src/ex_stage.sv ====
`timescale 1ns/10ps

module ex_stage (
  input  logic                    clk,
  input  logic                    rst_n,
  // alu and multiplier requests from ID
  input  ex_ops_pkg::alu_req_t    alu_req_i,
  input  logic                    alu_en_i,
  input  ex_ops_pkg::mult_req_t   mult_req_i,
  input  logic                    mult_en_i,
  // csr and lsu data
  input  logic                    csr_access_i,
  input  ex_types_pkg::word_t     csr_rdata_i,
  input  logic                    lsu_en_i,
  input  ex_types_pkg::word_t     lsu_rdata_i,
  // write controls from ID
  input  logic                    regfile_alu_we_i,
  input  ex_types_pkg::reg_addr_t regfile_alu_waddr_i,
  input  logic                    regfile_we_i,
  input  ex_types_pkg::reg_addr_t regfile_waddr_i,
  // stall inputs
  input  logic                    branch_in_ex_i,
  input  logic                    lsu_ready_ex_i,
  input  logic                    wb_ready_i,
  // write ports
  output ex_ops_pkg::wb_port_t    fw_o,
  output ex_ops_pkg::wb_port_t    wb_o,
  // to IF
  output ex_types_pkg::word_t     jump_target_o,
  output logic                    branch_decision_o,
  output logic                    mult_multicycle_o,
  output logic                    ex_ready_o,
  output logic                    ex_valid_o
);

  import ex_types_pkg::*;

  word_t alu_result;
  logic  alu_cmp_result;
  word_t mult_result;
  logic  mult_ready;
  // every unit downstream can take data
  logic  units_ready;

  ////////////////////////////////////////////////////////////
  // units
  ////////////////////////////////////////////////////////////

  ex_alu i_ex_alu (
    .alu_req_i           (alu_req_i),
    .alu_en_i            (alu_en_i),
    .result_o            (alu_result),
    .comparison_result_o (alu_cmp_result)
  );

  ex_mult i_ex_mult (
    .clk               (clk),
    .rst_n             (rst_n),
    .mult_req_i        (mult_req_i),
    .mult_en_i         (mult_en_i),
    .ex_ready_i        (ex_ready_o),
    .result_o          (mult_result),
    .mult_ready_o      (mult_ready),
    .mult_multicycle_o (mult_multicycle_o)
  );

  ex_writeback i_ex_writeback (
    .clk                 (clk),
    .rst_n               (rst_n),
    .alu_en_i            (alu_en_i),
    .mult_en_i           (mult_en_i),
    .csr_access_i        (csr_access_i),
    .alu_result_i        (alu_result),
    .mult_result_i       (mult_result),
    .csr_rdata_i         (csr_rdata_i),
    .lsu_rdata_i         (lsu_rdata_i),
    .regfile_alu_we_i    (regfile_alu_we_i),
    .regfile_we_i        (regfile_we_i),
    .regfile_alu_waddr_i (regfile_alu_waddr_i),
    .regfile_waddr_i     (regfile_waddr_i),
    .ex_valid_i          (ex_valid_o),
    .wb_ready_i          (wb_ready_i),
    .fw_o                (fw_o),
    .wb_o                (wb_o)
  );

  ////////////////////////////////////////////////////////////
  // branch and stall
  ////////////////////////////////////////////////////////////

  assign jump_target_o     = alu_req_i.operand_c;
  assign branch_decision_o = alu_cmp_result;

  assign units_ready = mult_ready & lsu_ready_ex_i & wb_ready_i;

  // a branch in EX finishes without WB
  assign ex_ready_o = units_ready | branch_in_ex_i;
  assign ex_valid_o = (alu_en_i | mult_en_i | csr_access_i | lsu_en_i) & units_ready;

endmodule

// ==== verification/ex_model.svh ====
`ifndef EX_MODEL_SVH
`define EX_MODEL_SVH

////////////////////////////////////////////////////////////
// reference model state
////////////////////////////////////////////////////////////

// EX/WB load port register
logic        m_lsu_we;
reg_addr_t   m_lsu_waddr;
// multiplier FSM and its held high word
mult_state_e m_mult_state;
word_t       m_mult_high;

// expected outputs of the current cycle
wb_port_t exp_fw;
wb_port_t exp_wb;
word_t    exp_jump_target;
logic     exp_branch;
logic     exp_multicycle;
logic     exp_ready;
logic     exp_valid;

task automatic reset_model();
  m_lsu_we     = 1'b0;
  m_lsu_waddr  = '0;
  m_mult_state = MULT_IDLE;
  m_mult_high  = '0;
endtask

// branch compares, slt and sltu share the less-than bit
function automatic logic compare_expected(alu_req_t req);
  case (req.op)
    ALU_EQ:            return req.operand_a == req.operand_b;
    ALU_NE:            return req.operand_a != req.operand_b;
    ALU_LT, ALU_SLT:   return $signed(req.operand_a) < $signed(req.operand_b);
    ALU_GE:            return $signed(req.operand_a) >= $signed(req.operand_b);
    ALU_LTU, ALU_SLTU: return req.operand_a < req.operand_b;
    ALU_GEU:           return req.operand_a >= req.operand_b;
    default:           return 1'b0;
  endcase
endfunction

function automatic word_t alu_expected(alu_req_t req);
  word_t  a;
  word_t  b;
  shamt_t sh;
  a  = req.operand_a;
  b  = req.operand_b;
  sh = req.operand_b[`EX_SHAMT_W-1:0];
  case (req.op)
    ALU_ADD: return a + b;
    ALU_SUB: return a - b;
    ALU_AND: return a & b;
    ALU_OR:  return a | b;
    ALU_XOR: return a ^ b;
    ALU_SLL: return a << sh;
    ALU_SRL: return a >> sh;
    // negative values shift in ones, done on the inverted word
    ALU_SRA: return a[`EX_XLEN-1] ? ~(~a >> sh) : (a >> sh);
    // compare group, flag in bit 0
    default: return word_t'(compare_expected(req));
  endcase
endfunction

// 64-bit product from plain integer arithmetic
function automatic dword_t product_expected(mult_req_t req);
  longint sa;
  longint sb;
  longint ub;
  sa = longint'($signed(req.operand_a));
  sb = longint'($signed(req.operand_b));
  ub = longint'(dword_t'(req.operand_b));
  case (req.op)
    MULT_MULH:   return dword_t'(sa * sb);
    MULT_MULHSU: return dword_t'(sa * ub);
    default:     return dword_t'(req.operand_a) * dword_t'(req.operand_b);
  endcase
endfunction

// outputs from the current inputs and model state
task automatic predict_outputs();
  dword_t p;
  logic   mult_ready;
  logic   units_ready;
  word_t  mult_res;
  p              = product_expected(mult_req);
  // first cycle of a high op stalls
  mult_ready     = !(m_mult_state == MULT_IDLE && mult_en && mult_req.op != MULT_MUL);
  exp_multicycle = (m_mult_state == MULT_HIGH_DONE);
  mult_res       = exp_multicycle ? m_mult_high : p[`EX_XLEN-1:0];
  units_ready    = mult_ready & lsu_ready_ex & wb_ready;
  exp_ready      = units_ready | branch_in_ex;
  exp_valid      = (alu_en | mult_en | csr_access | lsu_en) & units_ready;
  exp_fw.we      = regfile_alu_we;
  exp_fw.waddr   = regfile_alu_waddr;
  // csr over mult over alu
  if (csr_access) begin
    exp_fw.data = csr_rdata;
  end else if (mult_en) begin
    exp_fw.data = mult_res;
  end else if (alu_en) begin
    exp_fw.data = alu_expected(alu_req);
  end else begin
    exp_fw.data = '0;
  end
  exp_wb.we       = m_lsu_we;
  exp_wb.waddr    = m_lsu_waddr;
  exp_wb.data     = lsu_rdata;
  exp_jump_target = alu_req.operand_c;
  exp_branch      = compare_expected(alu_req);
endtask

// state update at the rising edge, after predict_outputs
task automatic update_model_state();
  dword_t p;
  p = product_expected(mult_req);
  if (exp_valid) begin
    m_lsu_we = regfile_we;
    if (regfile_we) begin
      m_lsu_waddr = regfile_waddr;
    end
  end else if (wb_ready) begin
    m_lsu_we = 1'b0;
  end
  case (m_mult_state)
    MULT_IDLE: begin
      if (mult_en && mult_req.op != MULT_MUL) begin
        m_mult_state = MULT_HIGH_DONE;
        m_mult_high  = p[2*`EX_XLEN-1:`EX_XLEN];
      end
    end
    default: begin
      if (exp_ready) begin
        m_mult_state = MULT_IDLE;
      end
    end
  endcase
endtask

`endif

// ==== verification/tb_ex_stage.sv ====
`timescale 1ns/10ps
`include "ex_params.svh"

module tb_ex_stage;

  import ex_types_pkg::*;
  import ex_ops_pkg::*;

  localparam int NUM_CYCLES   = 2000;
  localparam int RESET_CYCLES = 3;
  localparam int CLK_PERIOD   = 40;

  logic      clk;
  logic      rst_n;
  // ID side request
  alu_req_t  alu_req;
  logic      alu_en;
  mult_req_t mult_req;
  logic      mult_en;
  logic      csr_access;
  word_t     csr_rdata;
  logic      lsu_en;
  word_t     lsu_rdata;
  logic      regfile_alu_we;
  reg_addr_t regfile_alu_waddr;
  logic      regfile_we;
  reg_addr_t regfile_waddr;
  // stall inputs
  logic      branch_in_ex;
  logic      lsu_ready_ex;
  logic      wb_ready;
  // DUT outputs
  wb_port_t  fw;
  wb_port_t  wb;
  word_t     jump_target;
  logic      branch_decision;
  logic      mult_multicycle;
  logic      ex_ready;
  logic      ex_valid;

  integer    seed;
  // ID moves to a new instruction when EX took the last one
  logic      take_new;

  `include "ex_model.svh"

  ex_stage i_ex_stage (
    .clk                 (clk),
    .rst_n               (rst_n),
    .alu_req_i           (alu_req),
    .alu_en_i            (alu_en),
    .mult_req_i          (mult_req),
    .mult_en_i           (mult_en),
    .csr_access_i        (csr_access),
    .csr_rdata_i         (csr_rdata),
    .lsu_en_i            (lsu_en),
    .lsu_rdata_i         (lsu_rdata),
    .regfile_alu_we_i    (regfile_alu_we),
    .regfile_alu_waddr_i (regfile_alu_waddr),
    .regfile_we_i        (regfile_we),
    .regfile_waddr_i     (regfile_waddr),
    .branch_in_ex_i      (branch_in_ex),
    .lsu_ready_ex_i      (lsu_ready_ex),
    .wb_ready_i          (wb_ready),
    .fw_o                (fw),
    .wb_o                (wb),
    .jump_target_o       (jump_target),
    .branch_decision_o   (branch_decision),
    .mult_multicycle_o   (mult_multicycle),
    .ex_ready_o          (ex_ready),
    .ex_valid_o          (ex_valid)
  );

  always #(CLK_PERIOD/2) clk = ~clk;

  ////////////////////////////////////////////////////////////
  // error handling and compares
  ////////////////////////////////////////////////////////////

  task automatic fail_run(string reason);
    $display("%s", reason);
    $display("TEST FAIL");
    $fatal(1, "stopping at first error");
  endtask

  task automatic check_word(string name, word_t expected, word_t actual);
    if (actual !== expected) begin
      fail_run($sformatf("CHECK FAILED %s expected 0x%h actual 0x%h", name, expected, actual));
    end
  endtask

  task automatic check_port(string name, wb_port_t expected, wb_port_t actual);
    if (actual !== expected) begin
      fail_run($sformatf("CHECK FAILED %s expected 0x%h actual 0x%h", name, expected, actual));
    end
  endtask

  task automatic check_bit(string name, logic expected, logic actual);
    if (actual !== expected) begin
      fail_run($sformatf("CHECK FAILED %s expected 0x%h actual 0x%h", name, expected, actual));
    end
  endtask

  ////////////////////////////////////////////////////////////
  // stimulus
  ////////////////////////////////////////////////////////////

  function automatic word_t rand_word();
    word_t w;
    w = $random(seed);
    return w;
  endfunction

  // true about once in n draws
  function automatic logic chance(int n);
    int r;
    r = $random(seed);
    return (r % n) == 0;
  endfunction

  task automatic clear_inputs();
    alu_req           = '0;
    alu_en            = 1'b0;
    mult_req          = '0;
    mult_en           = 1'b0;
    csr_access        = 1'b0;
    csr_rdata         = '0;
    lsu_en            = 1'b0;
    lsu_rdata         = '0;
    regfile_alu_we    = 1'b0;
    regfile_alu_waddr = '0;
    regfile_we        = 1'b0;
    regfile_waddr     = '0;
    branch_in_ex      = 1'b0;
    lsu_ready_ex      = 1'b0;
    wb_ready          = 1'b0;
  endtask

  // new instruction, at most one of alu, mult, lsu
  task automatic drive_instruction();
    word_t r;
    r                  = rand_word();
    alu_en             = (r[1:0] == 2'd0);
    mult_en            = (r[1:0] == 2'd1);
    lsu_en             = (r[1:0] == 2'd2);
    alu_req.op         = alu_op_e'(r[7:4]);
    mult_req.op        = mult_op_e'(r[9:8]);
    regfile_alu_we     = r[10];
    regfile_we         = r[11];
    regfile_alu_waddr  = r[17:12];
    regfile_waddr      = r[23:18];
    alu_req.operand_a  = rand_word();
    alu_req.operand_b  = rand_word();
    alu_req.operand_c  = rand_word();
    mult_req.operand_a = rand_word();
    mult_req.operand_b = rand_word();
    csr_access         = chance(4);
    csr_rdata          = rand_word();
  endtask

  // stall inputs and load data change every cycle
  task automatic drive_stall();
    branch_in_ex = chance(8);
    lsu_ready_ex = !chance(8);
    wb_ready     = !chance(4);
    lsu_rdata    = rand_word();
  endtask

  task automatic check_outputs();
    predict_outputs();
    check_port("fw_o", exp_fw, fw);
    check_port("wb_o", exp_wb, wb);
    check_word("jump_target_o", exp_jump_target, jump_target);
    check_bit("branch_decision_o", exp_branch, branch_decision);
    check_bit("mult_multicycle_o", exp_multicycle, mult_multicycle);
    check_bit("ex_ready_o", exp_ready, ex_ready);
    check_bit("ex_valid_o", exp_valid, ex_valid);
  endtask

  ////////////////////////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////////////////////////

  initial begin
    seed     = 31179;
    clk      = 1'b0;
    rst_n    = 1'b0;
    take_new = 1'b1;
    clear_inputs();
    reset_model();
    repeat (RESET_CYCLES) @(posedge clk);
    #2;
    rst_n = 1'b1;
    #1;
    // reset values before any stimulus
    check_bit("wb_o.we", 1'b0, wb.we);
    check_bit("mult_multicycle_o", 1'b0, mult_multicycle);
    for (int cyc = 0; cyc < NUM_CYCLES; cyc++) begin
      @(posedge clk);
      #2;
      if (take_new) begin
        drive_instruction();
      end
      drive_stall();
      // sample at the falling edge, all settled
      #18;
      check_outputs();
      take_new = exp_ready;
      update_model_state();
    end
    $display("TEST PASS");
    $finish;
  end

  // watchdog, three times the nominal run
  initial begin
    #((NUM_CYCLES + RESET_CYCLES) * CLK_PERIOD * 3);
    fail_run("watchdog expired before all test cycles completed");
  end

endmodule

// ==== list.f ====
+incdir+common
+incdir+verification
common/ex_types_pkg.sv
common/ex_ops_pkg.sv
src/ex_alu.sv
src/ex_mult.sv
src/ex_writeback.sv
src/ex_stage.sv
verification/tb_ex_stage.sv

// ==== Makefile ====
TOP = tb_ex_stage

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f list.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir
